// ==== nco_apb_regs.sv ====
`timescale 1ns/1ps

module nco_apb_regs
  import nco_reg_pkg::*;
  import nco_core_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [APB_AW-1:0]   paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [APB_DW-1:0]   pwdata_i,
  output logic [APB_DW-1:0]   prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output logic [PERIOD_W-1:0] period_o,
  output logic                period_wen_o,
  output logic                enable_o,
  output logic                soft_rst_o
);

  logic              access;
  logic              wr_en;
  logic              addr_hit;
  logic              wr_ctrl;
  logic              wr_int;
  logic              wr_frac;
  logic              commit_d;
  logic [APB_DW-1:0] rdata;
  logic [APB_DW-1:0] status_w;

  logic [DATA_W-1:0] per_int_q;
  logic [DATA_W-1:0] per_frac_q;
  logic              pend_int_q;
  logic              pend_frac_q;
  logic              enable_q;
  logic              period_wen_q;
  logic              soft_rst_q;

  // no wait states
  assign pready_o = 1'b1;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  always_comb begin
    status_w              = '0;
    status_w[ST_INT_BIT]  = pend_int_q;
    status_w[ST_FRAC_BIT] = pend_frac_q;
    status_w[ST_EN_BIT]   = enable_q;
  end

  // address decode and readback mux
  always_comb begin
    addr_hit = 1'b1;
    wr_ctrl  = 1'b0;
    wr_int   = 1'b0;
    wr_frac  = 1'b0;
    rdata    = '0;
    case (paddr_i)
      REG_CTRL: begin
        wr_ctrl            = wr_en;
        rdata[CTRL_EN_BIT] = enable_q;
      end
      REG_PER_INT: begin
        wr_int              = wr_en;
        rdata[DATA_W-1:0]   = per_int_q;
      end
      REG_PER_FRAC: begin
        wr_frac             = wr_en;
        rdata[DATA_W-1:0]   = per_frac_q;
      end
      REG_STATUS: begin
        rdata = status_w;
      end
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  // status is read only
  assign pslverr_o = access & (~addr_hit | (pwrite_i & (paddr_i == REG_STATUS)));

  // commit once both halves have been written, counting this write
  assign commit_d = (wr_int | wr_frac) & (pend_int_q | wr_int) & (pend_frac_q | wr_frac);

  // staged period halves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      per_int_q  <= '0;
      per_frac_q <= '0;
    end else if (soft_rst_q) begin
      per_int_q  <= '0;
      per_frac_q <= '0;
    end else begin
      if (wr_int) begin
        per_int_q <= pwdata_i[DATA_W-1:0];
      end
      if (wr_frac) begin
        per_frac_q <= pwdata_i[DATA_W-1:0];
      end
    end
  end

  // pending flags, cleared by the commit pulse
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_int_q  <= 1'b0;
      pend_frac_q <= 1'b0;
    end else if (soft_rst_q) begin
      pend_int_q  <= 1'b0;
      pend_frac_q <= 1'b0;
    end else begin
      pend_int_q  <= wr_int | (pend_int_q & ~period_wen_q);
      pend_frac_q <= wr_frac | (pend_frac_q & ~period_wen_q);
    end
  end

  // enable survives soft reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
    end else if (wr_ctrl) begin
      enable_q <= pwdata_i[CTRL_EN_BIT];
    end
  end

  // one cycle control pulses
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      period_wen_q <= 1'b0;
      soft_rst_q   <= 1'b0;
    end else begin
      period_wen_q <= commit_d;
      soft_rst_q   <= wr_ctrl & pwdata_i[CTRL_SRST_BIT];
    end
  end

  assign period_o     = {per_int_q, per_frac_q};
  assign period_wen_o = period_wen_q;
  assign enable_o     = enable_q;
  assign soft_rst_o   = soft_rst_q;

endmodule

// ==== nco_core_pkg.sv ====
package nco_core_pkg;

  // width of each period half and of the cycle count
  localparam int unsigned DATA_W = 8;

  // fractional bits of the fixed-point period
  localparam int unsigned FRAC_W = DATA_W;

  // full period is integer part on top of fractional part
  localparam int unsigned PERIOD_W = 2 * DATA_W;

endpackage

// ==== nco_period_cnt.sv ====
`timescale 1ns/1ps

module nco_period_cnt
  import nco_core_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [DATA_W-1:0] quant_i,
  input  logic              period_wen_i,
  input  logic              enable_i,
  input  logic              soft_rst_i,
  output logic              clk_out_o
);

  logic [DATA_W-1:0] cnt_q;
  logic [DATA_W-1:0] last_cnt;
  logic [DATA_W-1:0] half;
  logic              wrap;
  logic              level;
  logic              clk_out_q;

  // terminal count of this output period
  assign last_cnt = quant_i - 1'b1;
  assign wrap     = (cnt_q == last_cnt);

  // high for the upper part of the period
  assign half  = quant_i / 2;
  assign level = (cnt_q > half);

  // modulo counter, restarts on a new period
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (soft_rst_i || period_wen_i) begin
      cnt_q <= '0;
    end else if (enable_i) begin
      if (wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // registered output level
  // a commit does not touch it, only soft reset and enable do
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_out_q <= 1'b0;
    end else if (soft_rst_i) begin
      clk_out_q <= 1'b0;
    end else if (enable_i) begin
      clk_out_q <= level;
    end
  end

  assign clk_out_o = clk_out_q;

endmodule

// ==== nco_phase_acc.sv ====
`timescale 1ns/1ps

module nco_phase_acc
  import nco_core_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [PERIOD_W-1:0] period_i,
  input  logic                period_wen_i,
  input  logic                enable_i,
  input  logic                soft_rst_i,
  output logic [DATA_W-1:0]   quant_o,
  output logic                period_wen_o,
  output logic                enable_o,
  output logic                soft_rst_o
);

  logic [PERIOD_W-1:0] period_q;
  logic [PERIOD_W-1:0] acc_q;
  logic [PERIOD_W-1:0] diff;
  logic [DATA_W-1:0]   acc_int;
  logic [FRAC_W-1:0]   acc_frac;
  logic [DATA_W-1:0]   quant;

  assign acc_int  = acc_q[PERIOD_W-1:FRAC_W];
  assign acc_frac = acc_q[FRAC_W-1:0];

  // round to nearest whole cycle
  always_comb begin
    if (acc_frac == {1'b1, {(FRAC_W-1){1'b0}}}) begin
      // exact half, parity of the integer part breaks the tie
      quant = acc_int + {{(DATA_W-1){1'b0}}, ^acc_int};
    end else if (acc_frac[FRAC_W-1]) begin
      quant = acc_int + 1'b1;
    end else begin
      quant = acc_int;
    end
  end

  // residue left after the cycles just issued
  assign diff = period_q - {quant, {FRAC_W{1'b0}}};

  // active period, loaded on commit only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      period_q <= '0;
    end else if (soft_rst_i) begin
      period_q <= '0;
    end else if (period_wen_i) begin
      period_q <= period_i;
    end
  end

  // error accumulator
  // load ignores enable so a new period is ready when it goes high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (soft_rst_i) begin
      acc_q <= '0;
    end else if (period_wen_i) begin
      acc_q <= period_i;
    end else if (enable_i) begin
      acc_q <= acc_q + diff;
    end
  end

  assign quant_o = quant;

  // controls pass straight on to the counter
  assign period_wen_o = period_wen_i;
  assign enable_o     = enable_i;
  assign soft_rst_o   = soft_rst_i;

endmodule

// ==== nco_reg_pkg.sv ====
package nco_reg_pkg;

  // apb bus widths
  localparam int unsigned APB_AW = 4;
  localparam int unsigned APB_DW = 32;

  // register offsets, word aligned
  typedef enum logic [APB_AW-1:0] {
    REG_CTRL     = 4'h0,
    REG_PER_INT  = 4'h4,
    REG_PER_FRAC = 4'h8,
    REG_STATUS   = 4'hC
  } nco_reg_e;

  // ctrl fields
  localparam int unsigned CTRL_EN_BIT   = 0;
  // self clearing, always reads back as 0
  localparam int unsigned CTRL_SRST_BIT = 1;

  // status fields, read only
  localparam int unsigned ST_INT_BIT  = 0;
  localparam int unsigned ST_FRAC_BIT = 1;
  localparam int unsigned ST_EN_BIT   = 2;

endpackage

// ==== nco_top.f ====
nco_reg_pkg.sv
nco_core_pkg.sv
nco_apb_regs.sv
nco_phase_acc.sv
nco_period_cnt.sv
nco_top.sv
tb_nco_top.sv

// ==== nco_top.sv ====
`timescale 1ns/1ps

module nco_top
  import nco_reg_pkg::*;
  import nco_core_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  output logic              clk_out_o
);

  // register stage to accumulator
  logic [PERIOD_W-1:0] period;
  logic                reg_period_wen;
  logic                reg_enable;
  logic                reg_soft_rst;

  // accumulator to counter
  logic [DATA_W-1:0]   quant;
  logic                acc_period_wen;
  logic                acc_enable;
  logic                acc_soft_rst;

  nco_apb_regs u_apb_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .period_o    (period),
    .period_wen_o(reg_period_wen),
    .enable_o    (reg_enable),
    .soft_rst_o  (reg_soft_rst)
  );

  nco_phase_acc u_phase_acc (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .period_i    (period),
    .period_wen_i(reg_period_wen),
    .enable_i    (reg_enable),
    .soft_rst_i  (reg_soft_rst),
    .quant_o     (quant),
    .period_wen_o(acc_period_wen),
    .enable_o    (acc_enable),
    .soft_rst_o  (acc_soft_rst)
  );

  nco_period_cnt u_period_cnt (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .quant_i     (quant),
    .period_wen_i(acc_period_wen),
    .enable_i    (acc_enable),
    .soft_rst_i  (acc_soft_rst),
    .clk_out_o   (clk_out_o)
  );

endmodule

// ==== tb_nco_top.sv ====
`timescale 1ns/1ps

module tb_nco_top
  import nco_reg_pkg::*;
  import nco_core_pkg::*;
();

  typedef struct packed {
    logic [PERIOD_W-1:0] period;
    logic [PERIOD_W-1:0] acc;
    logic [DATA_W-1:0]   cnt;
    logic                out;
  } model_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              clk_out;

  // expected state of the core after the last edge
  model_t            mdl = '0;

  // core controls as the write tasks expect them to reach the core
  logic [PERIOD_W-1:0] model_per = '0;
  logic                model_load = 1'b0;
  logic                model_srst = 1'b0;
  logic                model_en = 1'b0;

  int                seed;
  int                int_per [6] = '{2, 3, 7, 16, 100, 255};
  logic [15:0]       frac_per [5] = '{16'h0280, 16'h0380, 16'h0A80, 16'h0755, 16'h02C0};
  logic [31:0]       rnd;
  logic              held;

  nco_top DUT (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr),
    .clk_out_o(clk_out)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // round to whole cycles, exact half goes by integer parity
  function automatic logic [DATA_W-1:0] quantize(input logic [PERIOD_W-1:0] acc);
    logic [DATA_W-1:0] ip;
    logic [FRAC_W-1:0] fp;
    ip = acc[PERIOD_W-1:FRAC_W];
    fp = acc[FRAC_W-1:0];
    if (fp == (1 << (FRAC_W - 1))) begin
      if (^ip) begin
        return ip + 8'd1;
      end
      return ip;
    end else if (fp[FRAC_W-1]) begin
      return ip + 8'd1;
    end
    return ip;
  endfunction

  // one clock edge of accumulator, counter and output level
  function automatic model_t model_step(input model_t s, input logic load,
                                        input logic srst, input logic en,
                                        input logic [PERIOD_W-1:0] per);
    model_t              n;
    logic [DATA_W-1:0]   q;
    logic [DATA_W-1:0]   last;
    logic [PERIOD_W-1:0] whole;
    n     = s;
    q     = quantize(s.acc);
    last  = q - 8'd1;
    whole = {q, {FRAC_W{1'b0}}};
    if (srst) begin
      n = '0;
    end else begin
      if (en) begin
        n.out = (s.cnt > (q / 8'd2));
        n.acc = s.acc + s.period - whole;
        n.cnt = (s.cnt == last) ? 8'd0 : s.cnt + 8'd1;
      end
      // a commit reloads regardless of enable
      if (load) begin
        n.period = per;
        n.acc    = per;
        n.cnt    = '0;
      end
    end
    return n;
  endfunction

  // reference model, advanced at every rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      mdl <= '0;
    end else begin
      mdl <= model_step(mdl, model_load, model_srst, model_en, model_per);
    end
  end

  // output check against the model
  always @(posedge clk) begin
    if (rst_n) begin
      assert (clk_out === mdl.out) else
        stop_with_failure($sformatf("[FAIL] clk_out_o expected 0x%h actual 0x%h",
                                    mdl.out, clk_out));
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  // access phase, ends at the edge where pready_o is seen high
  task automatic finish_access(output logic [APB_DW-1:0] rdata, output logic err);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (pready === 1'b1) begin
        done = 1'b1;
      end else begin
        n++;
        if (n > 16) begin
          stop_with_failure("APB access saw no pready_o within 16 cycles");
        end
      end
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                           output logic err);
    logic [APB_DW-1:0] ignored;
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    finish_access(ignored, err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    finish_access(data, err);
  endtask

  task automatic write_ok(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic err;
    apb_write(addr, data, err);
    assert (err === 1'b0) else
      stop_with_failure($sformatf("[FAIL] pslverr_o at 0x%h expected 0x0 actual 0x%h",
                                  addr, err));
  endtask

  task automatic read_check(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] exp);
    logic [APB_DW-1:0] data;
    logic              err;
    apb_read(addr, data, err);
    assert (err === 1'b0) else
      stop_with_failure($sformatf("[FAIL] pslverr_o at 0x%h expected 0x0 actual 0x%h",
                                  addr, err));
    assert (data === exp) else
      stop_with_failure($sformatf("[FAIL] prdata_o at 0x%h expected 0x%h actual 0x%h",
                                  addr, exp, data));
  endtask

  task automatic expect_slverr(input logic [APB_AW-1:0] addr, input logic is_write);
    logic [APB_DW-1:0] data;
    logic              err;
    if (is_write) begin
      apb_write(addr, '0, err);
    end else begin
      apb_read(addr, data, err);
    end
    assert (err === 1'b1) else
      stop_with_failure($sformatf("[FAIL] pslverr_o at 0x%h expected 0x1 actual 0x%h",
                                  addr, err));
  endtask

  // called right after the completing write, so the load lands on the next edge
  task automatic expect_commit(input logic [PERIOD_W-1:0] per);
    model_per  = per;
    model_load = 1'b1;
    @(negedge clk);
    model_load = 1'b0;
  endtask

  task automatic expect_soft_reset();
    model_srst = 1'b1;
    @(negedge clk);
    model_srst = 1'b0;
  endtask

  task automatic write_ctrl(input logic en, input logic srst);
    logic [APB_DW-1:0] data;
    data                = '0;
    data[CTRL_EN_BIT]   = en;
    data[CTRL_SRST_BIT] = srst;
    write_ok(REG_CTRL, data);
    model_en = en;
    if (srst) begin
      expect_soft_reset();
    end
  endtask

  task automatic set_period(input logic [DATA_W-1:0] ip, input logic [DATA_W-1:0] fp);
    write_ok(REG_PER_INT, {24'h0, ip});
    write_ok(REG_PER_FRAC, {24'h0, fp});
    expect_commit({ip, fp});
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  initial begin
    seed    = 32'h2714_7a9b;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // register access and pending flags
    write_ok(REG_PER_INT, 32'h05);
    read_check(REG_PER_INT, 32'h05);
    read_check(REG_STATUS, 32'h1);
    write_ok(REG_PER_FRAC, 32'h40);
    expect_commit({8'h05, 8'h40});
    read_check(REG_PER_FRAC, 32'h40);
    read_check(REG_STATUS, 32'h0);
    write_ctrl(1'b1, 1'b0);
    read_check(REG_CTRL, 32'h1);
    read_check(REG_STATUS, 32'h4);
    expect_slverr(4'h2, 1'b0);
    expect_slverr(4'h7, 1'b1);
    expect_slverr(REG_STATUS, 1'b1);
    run_cycles(60);

    // one half alone keeps the old period running
    write_ok(REG_PER_INT, 32'h09);
    read_check(REG_STATUS, 32'h5);
    run_cycles(60);
    write_ok(REG_PER_FRAC, 32'hC0);
    expect_commit({8'h09, 8'hC0});
    run_cycles(60);

    // whole periods
    for (int i = 0; i < 6; i++) begin
      set_period(int_per[i][7:0], 8'h00);
      run_cycles(3 * int_per[i] + 20);
    end

    // fractional periods, ties first
    for (int i = 0; i < 5; i++) begin
      set_period(frac_per[i][15:8], frac_per[i][7:0]);
      run_cycles(400);
    end
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      set_period(8'd2 + 8'(rnd[15:0] % 16'd254), rnd[23:16]);
      run_cycles(400);
    end

    // enable low freezes the output, even across a commit
    write_ctrl(1'b0, 1'b0);
    @(negedge clk);
    held = clk_out;
    run_cycles(40);
    set_period(8'h04, 8'h80);
    run_cycles(20);
    assert (clk_out === held) else
      stop_with_failure($sformatf("[FAIL] clk_out_o expected 0x%h actual 0x%h",
                                  held, clk_out));
    write_ctrl(1'b1, 1'b0);
    run_cycles(200);

    // soft reset with a half still pending
    write_ok(REG_PER_INT, 32'h33);
    write_ctrl(1'b1, 1'b1);
    assert (clk_out === 1'b0) else
      stop_with_failure($sformatf("[FAIL] clk_out_o expected 0x0 actual 0x%h", clk_out));
    read_check(REG_STATUS, 32'h4);
    read_check(REG_PER_INT, 32'h0);
    read_check(REG_PER_FRAC, 32'h0);
    read_check(REG_CTRL, 32'h1);
    run_cycles(300);
    set_period(8'h03, 8'h55);
    run_cycles(100);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
